/* verilog/stack_calc_pkg.sv */
package stack_calc_pkg;

    //////////////////////////////////////////////////
    // Widths and register map
    //////////////////////////////////////////////////

    localparam int data_w = 8;                  // Default datapath width

    localparam logic [7:0] REG_CMD    = 8'h00;  // W: opcode + immediate
    localparam logic [7:0] REG_STATUS = 8'h04;  // R: count/flags, W: error clear
    localparam logic [7:0] REG_TOP    = 8'h08;  // R: top of stack

    // Field positions inside the 32-bit bus words
    localparam int CMD_IMM_LSB    = 0;          // Immediate in pwdata[7:0]
    localparam int CMD_OP_LSB     = 8;          // Opcode in pwdata[10:8]
    localparam int STAT_EMPTY_BIT = 8;
    localparam int STAT_FULL_BIT  = 9;
    localparam int STAT_ERR_BIT   = 16;         // Sticky, write 1 to clear

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_PUSH, OP_POP, OP_DUP,                // Stack only
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR   // Binary, need two entries
    } calc_op_e;

    typedef enum logic [1:0] {STK_NONE, STK_PUSH, STK_POP} stack_op_e;

    typedef enum logic [2:0] {S_IDLE, S_POP_A, S_POP_B, S_PUSH, S_DONE} seq_state_e;

    // Command as handed from the bus side to the sequencer
    typedef struct packed {
        calc_op_e   op;
        logic [7:0] imm;
    } calc_cmd_t;

    // APB master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

/* verilog/data_stack.sv */
`timescale 1ns/1ps

module data_stack
    import stack_calc_pkg::*;
#(
    parameter int WIDTH      = data_w,
    parameter int DEPTH_LOG2 = 4,
    localparam int COUNT_W   = DEPTH_LOG2 + 1   // Holds 0 .. 2**DEPTH_LOG2
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  stack_op_e          stack_op,        // One push or pop per clock
    input  logic [WIDTH-1:0]   push_data,
    output logic [WIDTH-1:0]   top,             // Value the next pop removes
    output logic [COUNT_W-1:0] count            // Elements held
);

    localparam int ENTRIES = 2**DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [ENTRIES];       // Slot 0 is the bottom
    logic [DEPTH_LOG2-1:0] wr_idx;              // First free slot
    logic [DEPTH_LOG2-1:0] below_idx;           // Slot under the current top
    logic [COUNT_W-1:0]    below_cnt;

    assign wr_idx    = count[DEPTH_LOG2-1:0];   // Wraps only when full, caller blocks that
    assign below_cnt = count - COUNT_W'(2);
    assign below_idx = below_cnt[DEPTH_LOG2-1:0];

    //////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (stack_op == STK_PUSH)
            mem[wr_idx] <= push_data;
    end

    //////////////////////////////////////////////////
    // Count and registered top
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count <= '0;
            top   <= '0;
        end
        else
        begin
            case (stack_op)
                STK_PUSH:
                begin
                    count <= count + COUNT_W'(1);
                    top   <= push_data;                 // New element is the top at once
                end
                STK_POP:
                begin
                    count <= count - COUNT_W'(1);
                    // Entry below becomes top, zero once the last one leaves
                    if (count > COUNT_W'(1))
                        top <= mem[below_idx];
                    else
                        top <= '0;
                end
                default:
                begin
                    count <= count;                     // Hold
                end
            endcase
        end
    end

endmodule

/* verilog/stack_alu.sv */
`timescale 1ns/1ps

module stack_alu
    import stack_calc_pkg::*;
#(
    parameter int WIDTH = data_w
)
(
    input  calc_op_e         op,
    input  logic [WIDTH-1:0] a,         // Former top of stack
    input  logic [WIDTH-1:0] b,         // Entry that sat below it
    output logic [WIDTH-1:0] result
);

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    // b is the left operand so SUB reads as below minus top
    always_comb
    begin
        case (op)
            OP_ADD:
                result = b + a;         // Wraps mod 2**WIDTH
            OP_SUB:
                result = b - a;         // Borrow dropped
            OP_AND:
                result = b & a;
            OP_OR:
                result = b | a;
            OP_XOR:
                result = b ^ a;
            default:
            begin
                // Stack-only opcodes never reach the push mux with this value
                result = b;
            end
        endcase
    end

endmodule

/* verilog/stack_sequencer.sv */
`timescale 1ns/1ps

module stack_sequencer
    import stack_calc_pkg::*;
#(
    parameter int WIDTH      = data_w,
    parameter int DEPTH_LOG2 = 4,
    localparam int COUNT_W   = DEPTH_LOG2 + 1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,   // One-cycle pulse from the bus side
    input  calc_cmd_t          cmd,
    output logic               cmd_done,    // High only in S_DONE
    output logic               cmd_err,     // Valid with cmd_done
    output stack_op_e          stack_op,
    output logic [WIDTH-1:0]   push_data,
    input  logic [WIDTH-1:0]   top,
    input  logic [COUNT_W-1:0] count
);

    localparam logic [COUNT_W-1:0] ENTRIES = COUNT_W'(2**DEPTH_LOG2);

    seq_state_e       state;
    stack_op_e        fin_op_q;             // Access for S_DONE and STK_NONE in idle
    logic             err_q;
    logic             is_binary;
    logic             reject;

    // Operands and command payload
    calc_op_e         op_q;
    logic             bin_q;
    logic [WIDTH-1:0] data_q;               // Immediate or copy of top
    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic [WIDTH-1:0] alu_result;

    //////////////////////////////////////////////////
    // Command check against current depth
    //////////////////////////////////////////////////

    assign is_binary = cmd.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    always_comb
    begin
        case (cmd.op)
            OP_PUSH: reject = (count == ENTRIES);                      // Overflow
            OP_POP:  reject = (count == '0);                           // Underflow
            OP_DUP:  reject = (count == '0) || (count == ENTRIES);
            default: reject = (count < COUNT_W'(2));                   // Needs two operands
        endcase
    end

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= S_IDLE;
            fin_op_q <= STK_NONE;
            err_q    <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        err_q <= reject;
                        if (reject)
                        begin
                            fin_op_q <= STK_NONE;           // Stack left untouched
                            state    <= S_DONE;
                        end
                        else if (is_binary)
                        begin
                            fin_op_q <= STK_PUSH;           // Result goes back last
                            state    <= S_POP_A;
                        end
                        else
                        begin
                            fin_op_q <= (cmd.op == OP_POP) ? STK_POP : STK_PUSH;
                            state    <= S_DONE;
                        end
                    end
                end
                S_POP_A: state <= S_POP_B;
                S_POP_B: state <= S_DONE;                   // Result push runs in S_DONE
                default:
                begin
                    fin_op_q <= STK_NONE;                   // Idle issues no stack access
                    state    <= S_IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && cmd_valid)
        begin
            op_q   <= cmd.op;
            bin_q  <= is_binary;
            data_q <= (cmd.op == OP_DUP) ? top : WIDTH'(cmd.imm);
        end
        if (state == S_POP_A)
            a_q <= top;                     // Top before the first pop
        if (state == S_POP_B)
            b_q <= top;                     // Entry exposed by that pop
    end

    stack_alu #(
        .WIDTH (WIDTH)
    ) i_stack_alu (
        .op     (op_q),
        .a      (a_q),
        .b      (b_q),
        .result (alu_result)
    );

    //////////////////////////////////////////////////
    // Outputs to stack and bus side
    //////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            S_POP_A, S_POP_B: stack_op = STK_POP;
            default:          stack_op = fin_op_q;      // Cleared again when leaving S_DONE
        endcase
    end

    assign push_data = bin_q ? alu_result : data_q;
    assign cmd_done  = (state == S_DONE);
    assign cmd_err   = (state == S_DONE) && err_q;

endmodule

/* verilog/apb_calc_regs.sv */
`timescale 1ns/1ps

module apb_calc_regs
    import stack_calc_pkg::*;
#(
    parameter int WIDTH      = data_w,
    parameter int DEPTH_LOG2 = 4,
    localparam int COUNT_W   = DEPTH_LOG2 + 1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,
    output logic               cmd_valid,   // First access cycle of a REG_CMD write
    output calc_cmd_t          cmd,
    input  logic               cmd_done,
    input  logic               cmd_err,
    input  logic [WIDTH-1:0]   top,
    input  logic [COUNT_W-1:0] count
);

    localparam logic [COUNT_W-1:0] ENTRIES = COUNT_W'(2**DEPTH_LOG2);

    logic        access;                    // APB access phase
    logic        cmd_wr;
    logic        stat_wr;
    logic        busy_q;                    // Command in flight
    logic        err_q;                     // Sticky error
    logic        empty;
    logic        full;
    logic [31:0] status_word;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign access  = apb_req.psel && apb_req.penable;
    assign cmd_wr  = access && apb_req.pwrite && (apb_req.paddr == REG_CMD);
    assign stat_wr = access && apb_req.pwrite && (apb_req.paddr == REG_STATUS);

    assign cmd_valid = cmd_wr && !busy_q;   // busy_q masks the later access cycles
    assign cmd.op    = calc_op_e'(apb_req.pwdata[CMD_OP_LSB +: $bits(calc_op_e)]);
    assign cmd.imm   = apb_req.pwdata[CMD_IMM_LSB +: 8];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy_q <= 1'b0;
        else if (cmd_valid)
            busy_q <= 1'b1;
        else if (cmd_done)
            busy_q <= 1'b0;                 // Transfer ends on this same edge
    end

    // Set by a rejected command and cleared by writing 1 to status bit 16
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            err_q <= 1'b0;
        else if (cmd_done && cmd_err)
            err_q <= 1'b1;
        else if (stat_wr && apb_req.pwdata[STAT_ERR_BIT])
            err_q <= 1'b0;
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    assign empty = (count == '0);
    assign full  = (count == ENTRIES);

    always_comb
    begin
        status_word                 = '0;
        status_word[COUNT_W-1:0]    = count;
        status_word[STAT_EMPTY_BIT] = empty;
        status_word[STAT_FULL_BIT]  = full;
        status_word[STAT_ERR_BIT]   = err_q;
    end

    // Only command writes add wait states
    assign apb_rsp.pready  = !cmd_wr || (busy_q && cmd_done);
    assign apb_rsp.pslverr = cmd_wr && cmd_err;

    always_comb
    begin
        apb_rsp.prdata = '0;                // Unmapped reads return zero
        if (access && !apb_req.pwrite)
        begin
            if (apb_req.paddr == REG_STATUS)
                apb_rsp.prdata = status_word;
            else if (apb_req.paddr == REG_TOP)
                apb_rsp.prdata = 32'(top);  // Stack already zeroes it when empty
        end
    end

endmodule

/* verilog/stack_calc_top.sv */
`timescale 1ns/1ps

module stack_calc_top
    import stack_calc_pkg::*;
#(
    parameter int WIDTH      = data_w,
    parameter int DEPTH_LOG2 = 4,
    localparam int COUNT_W   = DEPTH_LOG2 + 1
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // Bus side to sequencer
    logic               cmd_valid;
    calc_cmd_t          cmd;
    logic               cmd_done;
    logic               cmd_err;

    // Sequencer to stack and back
    stack_op_e          stack_op;
    logic [WIDTH-1:0]   push_data;
    logic [WIDTH-1:0]   top;
    logic [COUNT_W-1:0] count;

    apb_calc_regs #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_apb_calc_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .cmd_err   (cmd_err),
        .top       (top),           // Also read back over the bus
        .count     (count)
    );

    stack_sequencer #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_stack_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .cmd_err   (cmd_err),
        .stack_op  (stack_op),
        .push_data (push_data),
        .top       (top),
        .count     (count)
    );

    data_stack #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_data_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .stack_op  (stack_op),
        .push_data (push_data),
        .top       (top),
        .count     (count)
    );

endmodule

/* verif/stack_calc_props.sv */
`timescale 1ns/1ps

module stack_calc_props
    import stack_calc_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4,
    localparam int COUNT_W   = DEPTH_LOG2 + 1
)
(
    input logic               clk,
    input logic               rst_n,
    input apb_rsp_t           apb_rsp,
    input logic               cmd_valid,
    input calc_cmd_t          cmd,
    input logic               cmd_done,
    input stack_op_e          stack_op,
    input seq_state_e         seq_state,
    input logic [COUNT_W-1:0] count
);

    localparam logic [COUNT_W-1:0] ENTRIES = COUNT_W'(2**DEPTH_LOG2);

    logic binary_op;
    logic long_cmd;                             // Accepted binary op, pop pop push
    logic short_cmd;                            // Stack-only or rejected

    assign binary_op = cmd.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    assign long_cmd  = cmd_valid && binary_op && (count >= COUNT_W'(2));
    assign short_cmd = cmd_valid && !long_cmd;

    //////////////////////////////////////////////////
    // Bus and stack rules
    //////////////////////////////////////////////////

    slverr_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else $error("pslverr high while pready is low");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= ENTRIES)
        else $error("stack count above the number of entries");

    idle_no_stack_op: assert property (@(posedge clk) disable iff (!rst_n)
        (seq_state == S_IDLE) |-> (stack_op == STK_NONE))
        else $error("stack operation while the sequencer is idle");

    //////////////////////////////////////////////////
    // Command latency
    //////////////////////////////////////////////////

    short_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(short_cmd) |-> cmd_done)
        else $error("stack-only command not done one cycle after issue");

    long_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(long_cmd, 3) |-> cmd_done)
        else $error("binary command not done three cycles after issue");

    long_not_early: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(long_cmd) || $past(long_cmd, 2)) |-> !cmd_done)
        else $error("binary command done too early");

endmodule

bind stack_calc_top stack_calc_props #(
    .DEPTH_LOG2 (DEPTH_LOG2)
) i_stack_calc_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_rsp   (apb_rsp),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_done  (cmd_done),
    .stack_op  (stack_op),
    .seq_state (i_stack_sequencer.state),
    .count     (count)
);

/* verif/stack_calc_tb.sv */
`timescale 1ns/1ps

module stack_calc_tb
    import stack_calc_pkg::*;
();

    localparam int DEPTH_LOG2 = 2;
    localparam int ENTRIES    = 2**DEPTH_LOG2;      // Full after four pushes
    localparam int RST_CYCLES = 16;
    localparam int CMD_CYCLES = 200;                // Watchdog budget per command

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [7:0]  model [$];                         // Reference stack with the top at the back
    logic        model_err;                         // Expected sticky error
    logic [31:0] seed;
    int          cmd_issued  = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count  = 0;
    int          check_mark  = 0;                   // Counts at start of current test
    int          error_mark  = 0;
    int          cycles;

    calc_op_e bin_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    stack_calc_top #(
        .WIDTH      (data_w),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_stack_calc_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    //////////////////////////////////////////////////
    // Clock and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    // Limit grows with every command issued
    initial
    begin
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (cycles < RST_CYCLES + CMD_CYCLES * (cmd_issued + 1));
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;    // Numerical Recipes LCG
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            error_count++;
            $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    // One APB transfer with inputs changed on the falling edge only
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic err,
                                output logic [31:0] rdata, output int waits);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;                     // Access phase
        waits = 0;
        @(posedge clk);
        while (!apb_rsp.pready)
        begin
            waits++;
            @(posedge clk);
        end
        err   = apb_rsp.pslverr;                    // Sampled on the completing edge
        rdata = apb_rsp.prdata;
        @(negedge clk);
        apb_req = '0;
    endtask

    // Apply one command to the reference stack
    task automatic predict_cmd(input calc_op_e op, input logic [7:0] imm,
                               output logic rejected);
        logic [7:0] a;
        logic [7:0] b;
        int         n;
        n = model.size();
        case (op)
            OP_PUSH: rejected = (n == ENTRIES);     // Overflow
            OP_POP:  rejected = (n == 0);           // Underflow
            OP_DUP:  rejected = (n == 0) || (n == ENTRIES);
            default: rejected = (n < 2);
        endcase
        if (rejected)
            model_err = 1'b1;                       // Stack untouched
        else if (op == OP_PUSH)
            model.push_back(imm);
        else if (op == OP_POP)
            void'(model.pop_back());
        else if (op == OP_DUP)
            model.push_back(model[n-1]);
        else
        begin
            a = model.pop_back();                   // Former top
            b = model.pop_back();
            case (op)
                OP_ADD:  model.push_back(b + a);
                OP_SUB:  model.push_back(b - a);    // Below minus top
                OP_AND:  model.push_back(b & a);
                OP_OR:   model.push_back(b | a);
                default: model.push_back(b ^ a);
            endcase
        end
    endtask

    task automatic check_state();
        logic [31:0] exp_status;
        logic [31:0] rdata;
        logic        err;
        int          waits;
        exp_status      = '0;
        exp_status[4:0] = 5'(model.size());
        exp_status[8]   = (model.size() == 0);      // Empty
        exp_status[9]   = (model.size() == ENTRIES);
        exp_status[16]  = model_err;
        apb_transfer(1'b0, REG_STATUS, '0, err, rdata, waits);
        check_value("status", rdata, exp_status);
        apb_transfer(1'b0, REG_TOP, '0, err, rdata, waits);
        check_value("top", rdata, (model.size() == 0) ? 32'h0 : 32'(model[model.size()-1]));
        check_value("read_wait_states", 32'(waits), 32'd0);
    endtask

    task automatic issue_cmd(input calc_op_e op, input logic [7:0] imm);
        logic        exp_err;
        logic        err;
        logic [31:0] rdata;
        int          waits;
        predict_cmd(op, imm, exp_err);
        cmd_issued++;
        apb_transfer(1'b1, REG_CMD, {21'd0, op, imm}, err, rdata, waits);
        check_value("pslverr", 32'(err), 32'(exp_err));
        // Accepted binary ops pop twice and then push
        check_value("cmd_wait_states", 32'(waits), (!exp_err && op >= OP_ADD) ? 32'd3 : 32'd1);
        check_state();
    endtask

    task automatic clear_error();
        logic        err;
        logic [31:0] rdata;
        int          waits;
        apb_transfer(1'b1, REG_STATUS, 32'h0001_0000, err, rdata, waits);
        model_err = 1'b0;
        check_value("status_write_wait_states", 32'(waits), 32'd0);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - check_mark, error_count - error_mark);
        check_mark = check_count;
        error_mark = error_count;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        apb_req   = '0;
        rst_n     = 1'b0;
        model_err = 1'b0;
        seed      = 32'he173;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_state();                              // Empty after reset
        finish_test("reset_state");

        issue_cmd(OP_PUSH, 8'h11);
        issue_cmd(OP_PUSH, 8'h22);
        issue_cmd(OP_PUSH, 8'h33);
        repeat (3) issue_cmd(OP_POP, 8'h00);        // Back down to empty
        finish_test("push_pop");

        foreach (bin_ops[i])
        begin
            issue_cmd(OP_PUSH, 8'h9c);
            issue_cmd(OP_PUSH, 8'hc7);              // ADD and SUB both wrap
            issue_cmd(bin_ops[i], 8'h00);
            issue_cmd(OP_POP, 8'h00);
        end
        issue_cmd(OP_PUSH, 8'h4d);
        issue_cmd(OP_DUP, 8'h00);
        repeat (2) issue_cmd(OP_POP, 8'h00);
        finish_test("arithmetic");

        issue_cmd(OP_POP, 8'h00);                   // Pop on empty
        clear_error();
        issue_cmd(OP_PUSH, 8'h01);
        issue_cmd(OP_SUB, 8'h00);                   // Single operand
        repeat (3) issue_cmd(OP_PUSH, 8'h02);
        issue_cmd(OP_PUSH, 8'h05);                  // Fifth push
        issue_cmd(OP_DUP, 8'h00);                   // DUP on full stack
        clear_error();
        check_state();
        repeat (ENTRIES) issue_cmd(OP_POP, 8'h00);
        finish_test("overflow_underflow");

        repeat (200)
        begin
            seed = next_random(seed);
            issue_cmd(calc_op_e'(seed[18:16]), seed[27:20]);
            if (seed[31:28] == 4'hf)
                clear_error();                      // Now and then
        end
        finish_test("random_sequence");

        issue_cmd(OP_PUSH, 8'h70);
        issue_cmd(OP_PUSH, 8'h90);
        issue_cmd(OP_ADD, 8'h00);
        issue_cmd(OP_DUP, 8'h00);
        issue_cmd(OP_XOR, 8'h00);
        issue_cmd(OP_POP, 8'h00);
        finish_test("wait_states");

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* filelist.f */
verilog/stack_calc_pkg.sv
verilog/data_stack.sv
verilog/stack_alu.sv
verilog/stack_sequencer.sv
verilog/apb_calc_regs.sv
verilog/stack_calc_top.sv
verif/stack_calc_props.sv
verif/stack_calc_tb.sv

/* Makefile */
# Verilator flow for the stack calculator testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module stack_calc_tb -f filelist.f \
		--Mdir obj_dir -o sim_stack_calc

run: compile
	./obj_dir/sim_stack_calc 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation FAILED, run ended early"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
